/* design/scanline_pkg.sv */
package scanline_pkg;

  ////////////////////////////////////////
  // widths and pipeline
  ////////////////////////////////////////

  localparam int color_width      = 8;  // bits per channel
  localparam int proc_stages      = 10; // fixed latency, input to output
  localparam int bloom_calc_width = 8;  // fraction bits in the bloom math
  localparam int bloom_width      = 5;  // bloom setting, 0..31

  ////////////////////////////////////////
  // data types
  ////////////////////////////////////////

  typedef logic [color_width-1:0] color_t;

  // reference is 2*c or G + (R+B)/2, so one extra bit
  typedef logic [color_width:0] ref_t;

  // strengths, distances and positions are 0.8 fixed point
  typedef logic [7:0] str_t;

  typedef struct packed {
    color_t r;  // high byte
    color_t g;
    color_t b;  // low byte
  } vdata_t;

  ////////////////////////////////////////
  // scanline constants
  ////////////////////////////////////////

  localparam str_t sl_profile_width = 8'h40; // slope of the profile, 0.25
  localparam str_t pos_half         = 8'h80; // center of the line

  // fixed thresholds, fraction of the line left undarkened
  localparam str_t thr_thin   = 8'h30; // 0.1875
  localparam str_t thr_normal = 8'h20; // 0.125
  localparam str_t thr_thick  = 8'h10; // 0.0625

  ////////////////////////////////////////
  // mode selects
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    THIN     = 2'b00,
    NORMAL   = 2'b01,
    THICK    = 2'b10,
    ADAPTIVE = 2'b11   // threshold follows the reference value
  } sl_thickness_e;

  typedef enum logic {
    RECT     = 1'b0,
    FLAT_TOP = 1'b1
  } sl_profile_e;

endpackage

/* design/scanline_decode.sv */
`timescale 1ns/1ps

module scanline_decode (
  input  logic                        VCLK_i,
  input  logic                        nVRST_i,
  input  scanline_pkg::color_t        r_i,
  input  scanline_pkg::color_t        g_i,
  input  scanline_pkg::color_t        b_i,
  input  logic                        sl_per_channel_i,
  input  scanline_pkg::sl_thickness_e sl_thickness_i,
  input  scanline_pkg::sl_profile_e   sl_profile_i,
  input  scanline_pkg::str_t          sl_rel_pos_i,
  output scanline_pkg::str_t          dist_r_o,
  output scanline_pkg::str_t          dist_g_o,
  output scanline_pkg::str_t          dist_b_o,
  output logic                        draw_r_o,
  output logic                        draw_g_o,
  output logic                        draw_b_o,
  output logic                        max_r_o,
  output logic                        max_g_o,
  output logic                        max_b_o,
  output scanline_pkg::ref_t          ref_r_o,
  output scanline_pkg::ref_t          ref_g_o,
  output scanline_pkg::ref_t          ref_b_o
);

  // channel index in the local arrays: 0 red, 1 green, 2 blue
  scanline_pkg::color_t               pix_0l [3];
  logic [scanline_pkg::color_width:0] rpb_0l;
  scanline_pkg::str_t                 pos_0l;
  scanline_pkg::str_t                 pos_1l;
  scanline_pkg::ref_t                 ref_1l [3];
  scanline_pkg::ref_t                 ref_2l [3];
  scanline_pkg::ref_t                 luma_w;
  scanline_pkg::str_t                 thr_w [3];
  scanline_pkg::str_t                 dist_w [3];
  logic [2:0]                         draw_w;
  logic [2:0]                         max_w;
  scanline_pkg::str_t                 dist_2l [3];
  logic [2:0]                         draw_2l;
  logic [2:0]                         max_2l;

  // threshold by thickness mode, adaptive ranges 0 to 0.25
  function automatic scanline_pkg::str_t thr_sel(
    input scanline_pkg::ref_t          ref_v,
    input scanline_pkg::sl_thickness_e mode
  );
    case (mode)
      scanline_pkg::THIN:   thr_sel = scanline_pkg::thr_thin;
      scanline_pkg::NORMAL: thr_sel = scanline_pkg::thr_normal;
      scanline_pkg::THICK:  thr_sel = scanline_pkg::thr_thick;
      default: begin
        thr_sel = {2'b00, ref_v[scanline_pkg::color_width:scanline_pkg::color_width-5]} +
                  ref_v[scanline_pkg::color_width-6]; // rounding bit
      end
    endcase
  endfunction

  ////////////////////////////////////////
  // stage 0 and 1: references, position
  ////////////////////////////////////////

  assign luma_w = {1'b0, pix_0l[1]} + {1'b0, rpb_0l[scanline_pkg::color_width:1]};

  always_ff @(posedge VCLK_i) begin
    pix_0l[0] <= r_i;
    pix_0l[1] <= g_i;
    pix_0l[2] <= b_i;
    rpb_0l    <= {1'b0, r_i} + {1'b0, b_i};
    // fold the lower half of the line onto the upper, 256 - pos
    pos_0l    <= (sl_rel_pos_i > scanline_pkg::pos_half) ? 8'h00 - sl_rel_pos_i
                                                         : sl_rel_pos_i;

    for (int ch = 0; ch < 3; ch++) begin
      ref_1l[ch] <= sl_per_channel_i ? {pix_0l[ch], 1'b0} : luma_w;
      ref_2l[ch] <= ref_1l[ch];
    end
    pos_1l <= pos_0l; // waits for the reference
  end

  ////////////////////////////////////////
  // stage 2: threshold, distance, flags
  ////////////////////////////////////////

  always_comb begin
    for (int ch = 0; ch < 3; ch++) begin
      thr_w[ch]  = thr_sel(ref_1l[ch], sl_thickness_i);
      dist_w[ch] = pos_1l - thr_w[ch];
      if (sl_profile_i == scanline_pkg::FLAT_TOP) begin
        // only past 0.125 beyond the threshold, then at full strength
        draw_w[ch] = (pos_1l > thr_w[ch]) & (|dist_w[ch][7:5]);
        max_w[ch]  = |dist_w[ch][7:5];
      end else begin
        draw_w[ch] = pos_1l > thr_w[ch];
        max_w[ch]  = pos_1l >= thr_w[ch] + scanline_pkg::sl_profile_width;
      end
    end
  end

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      draw_2l <= '0;
      max_2l  <= '0;
    end else begin
      draw_2l <= draw_w;
      max_2l  <= max_w;
    end
  end

  always_ff @(posedge VCLK_i) begin
    for (int ch = 0; ch < 3; ch++)
      dist_2l[ch] <= dist_w[ch];
  end

  assign dist_r_o = dist_2l[0];
  assign dist_g_o = dist_2l[1];
  assign dist_b_o = dist_2l[2];
  assign draw_r_o = draw_2l[0];
  assign draw_g_o = draw_2l[1];
  assign draw_b_o = draw_2l[2];
  assign max_r_o  = max_2l[0];
  assign max_g_o  = max_2l[1];
  assign max_b_o  = max_2l[2];
  assign ref_r_o  = ref_2l[0];
  assign ref_g_o  = ref_2l[1];
  assign ref_b_o  = ref_2l[2];

endmodule

/* design/scanline_execute.sv */
`timescale 1ns/1ps

module scanline_execute (
  input  logic                                 VCLK_i,
  input  logic                                 nVRST_i,
  input  logic                                 sl_en_i,
  input  scanline_pkg::sl_profile_e            sl_profile_i,
  input  scanline_pkg::str_t                   sl_strength_i,
  input  logic [scanline_pkg::bloom_width-1:0] sl_bloom_i,
  input  scanline_pkg::str_t                   dist_r_i,
  input  scanline_pkg::str_t                   dist_g_i,
  input  scanline_pkg::str_t                   dist_b_i,
  input  logic                                 draw_r_i,
  input  logic                                 draw_g_i,
  input  logic                                 draw_b_i,
  input  logic                                 max_r_i,
  input  logic                                 max_g_i,
  input  logic                                 max_b_i,
  input  scanline_pkg::ref_t                   ref_r_i,
  input  scanline_pkg::ref_t                   ref_g_i,
  input  scanline_pkg::ref_t                   ref_b_i,
  output scanline_pkg::str_t                   scale_r_o,
  output scanline_pkg::str_t                   scale_g_o,
  output scanline_pkg::str_t                   scale_b_o,
  output logic                                 draw_r_o,
  output logic                                 draw_g_o,
  output logic                                 draw_b_o
);

  // index 0 red, 1 green, 2 blue
  scanline_pkg::str_t dist_w [3];
  scanline_pkg::ref_t ref_w [3];
  logic [2:0]         draw_w;
  logic [2:0]         max_w;

  logic [scanline_pkg::color_width+scanline_pkg::bloom_width:0]      rb_prod_w [3];
  logic [2*scanline_pkg::color_width-1:0]                            str_prod_w [3];
  logic [scanline_pkg::color_width+scanline_pkg::bloom_calc_width:0] v_prod_w [3];

  scanline_pkg::str_t shape_3l [3];
  logic [2:0]         max_3l;
  scanline_pkg::ref_t rpre_3l [3];
  scanline_pkg::ref_t rpre_4l [3];
  scanline_pkg::str_t str_4l [3];
  scanline_pkg::str_t str_5l [3];
  scanline_pkg::ref_t v_5l [3];
  scanline_pkg::str_t b_6l [3];
  scanline_pkg::str_t k_7l [3];
  logic [2:0]         draw_l [3:7]; // draw flag per stage

  assign dist_w = '{dist_r_i, dist_g_i, dist_b_i};
  assign ref_w  = '{ref_r_i, ref_g_i, ref_b_i};
  assign draw_w = {draw_b_i, draw_g_i, draw_r_i};  // bit 0 is red
  assign max_w  = {max_b_i, max_g_i, max_r_i};

  always_comb begin
    for (int ch = 0; ch < 3; ch++) begin
      rb_prod_w[ch]  = ref_w[ch] * sl_bloom_i;
      str_prod_w[ch] = shape_3l[ch] * sl_strength_i;
      v_prod_w[ch]   = rpre_4l[ch] * str_4l[ch];
    end
  end

  ////////////////////////////////////////
  // flag pipeline, enable joins at 4
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      max_3l <= '0;
      for (int st = 3; st <= 7; st++)
        draw_l[st] <= '0;
    end else begin
      max_3l    <= max_w;
      draw_l[3] <= draw_w;
      draw_l[4] <= draw_l[3] & {3{sl_en_i}};
      for (int st = 5; st <= 7; st++)
        draw_l[st] <= draw_l[st-1];
    end
  end

  ////////////////////////////////////////
  // strength and bloom datapath
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i) begin
    for (int ch = 0; ch < 3; ch++) begin
      // stage 3: profile shape
      if (sl_profile_i == scanline_pkg::FLAT_TOP)
        shape_3l[ch] <= '0; // no slope, level comes from the max flag
      else
        shape_3l[ch] <= {dist_w[ch][5:0], dist_w[ch][5:4]};
      // bloom weight of the reference, ref * bloom / 32
      rpre_3l[ch] <= rb_prod_w[ch][scanline_pkg::color_width+scanline_pkg::bloom_width:
                                   scanline_pkg::bloom_width];

      // stage 4: scale by global strength
      str_4l[ch]  <= max_3l[ch] ? sl_strength_i
                                : str_prod_w[ch][2*scanline_pkg::color_width-1:
                                                 scanline_pkg::color_width];
      rpre_4l[ch] <= rpre_3l[ch];  // wait for strength

      // stage 5: bloom reduction value
      str_5l[ch] <= str_4l[ch];
      v_5l[ch]   <= v_prod_w[ch][scanline_pkg::color_width+scanline_pkg::bloom_calc_width:
                                 scanline_pkg::bloom_calc_width];

      // stage 6: clamp at zero
      if ({1'b0, str_5l[ch]} < v_5l[ch])
        b_6l[ch] <= '0;
      else
        b_6l[ch] <= str_5l[ch] - v_5l[ch][scanline_pkg::color_width-1:0];

      // stage 7: darkening factor
      k_7l[ch] <= 8'hff - b_6l[ch];
    end
  end

  assign scale_r_o = k_7l[0];
  assign scale_g_o = k_7l[1];
  assign scale_b_o = k_7l[2];
  assign draw_r_o  = draw_l[7][0];
  assign draw_g_o  = draw_l[7][1];
  assign draw_b_o  = draw_l[7][2];

endmodule

/* design/scanline_result.sv */
`timescale 1ns/1ps

module scanline_result (
  input  logic                 VCLK_i,
  input  logic                 nVRST_i,
  input  scanline_pkg::color_t r_i,
  input  scanline_pkg::color_t g_i,
  input  scanline_pkg::color_t b_i,
  input  logic                 hsync_i,
  input  logic                 vsync_i,
  input  logic                 de_i,
  input  scanline_pkg::str_t   scale_r_i,
  input  scanline_pkg::str_t   scale_g_i,
  input  scanline_pkg::str_t   scale_b_i,
  input  logic                 draw_r_i,
  input  logic                 draw_g_i,
  input  logic                 draw_b_i,
  output logic                 hsync_o,
  output logic                 vsync_o,
  output logic                 de_o,
  output scanline_pkg::vdata_t vdata_o
);

  // raw pixel delay, stages 0 to 8, index 0 red
  scanline_pkg::color_t pix_l [3][scanline_pkg::proc_stages-1];
  logic [scanline_pkg::proc_stages-2:0] hs_l, vs_l, de_l;

  scanline_pkg::color_t raw_w [3];
  scanline_pkg::str_t   scale_w [3];
  logic [2:0]           draw_w;
  logic [scanline_pkg::color_width+scanline_pkg::bloom_calc_width-1:0] sl_prod_w [3];
  scanline_pkg::color_t out_w [3];

  logic [2:0]           draw_8l;
  scanline_pkg::color_t sl_8l [3];

  assign raw_w   = '{r_i, g_i, b_i};
  assign scale_w = '{scale_r_i, scale_g_i, scale_b_i};
  assign draw_w  = {draw_b_i, draw_g_i, draw_r_i};

  always_comb begin
    for (int ch = 0; ch < 3; ch++) begin
      sl_prod_w[ch] = pix_l[ch][scanline_pkg::proc_stages-3] * scale_w[ch]; // stage 7 pixel
      out_w[ch]     = (de_l[scanline_pkg::proc_stages-2] && draw_8l[ch]) ?
                      sl_8l[ch] : pix_l[ch][scanline_pkg::proc_stages-2];
    end
  end

  ////////////////////////////////////////
  // pixel delay and darkened value
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i) begin
    for (int ch = 0; ch < 3; ch++) begin
      pix_l[ch][0] <= raw_w[ch];
      for (int st = 1; st < scanline_pkg::proc_stages-1; st++)
        pix_l[ch][st] <= pix_l[ch][st-1];
      // c * k / 256, to stage 8
      sl_8l[ch] <= sl_prod_w[ch][scanline_pkg::color_width+scanline_pkg::bloom_calc_width-1:
                                 scanline_pkg::bloom_calc_width];
    end
  end

  ////////////////////////////////////////
  // sync delay and output register
  ////////////////////////////////////////

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i) begin
      hs_l    <= '0;
      vs_l    <= '0;
      de_l    <= '0;
      draw_8l <= '0;
      hsync_o <= 1'b0;
      vsync_o <= 1'b0;
      de_o    <= 1'b0;
      vdata_o <= '0;
    end else begin
      hs_l    <= {hs_l[scanline_pkg::proc_stages-3:0], hsync_i};
      vs_l    <= {vs_l[scanline_pkg::proc_stages-3:0], vsync_i};
      de_l    <= {de_l[scanline_pkg::proc_stages-3:0], de_i};
      draw_8l <= draw_w;
      hsync_o <= hs_l[scanline_pkg::proc_stages-2];
      vsync_o <= vs_l[scanline_pkg::proc_stages-2];
      de_o    <= de_l[scanline_pkg::proc_stages-2];
      vdata_o <= {out_w[0], out_w[1], out_w[2]}; // red high
    end
  end

endmodule

/* design/scanline_emu.sv */
`timescale 1ns/1ps

module scanline_emu (
  input  logic                                 VCLK_i,
  input  logic                                 nVRST_i,
  input  logic                                 HSYNC_i,
  input  logic                                 VSYNC_i,
  input  logic                                 DE_i,
  input  scanline_pkg::vdata_t                 vdata_i,
  input  logic                                 sl_en_i,
  input  logic                                 sl_per_channel_i,
  input  scanline_pkg::sl_thickness_e          sl_thickness_i,
  input  scanline_pkg::sl_profile_e            sl_profile_i,
  input  scanline_pkg::str_t                   sl_rel_pos_i,
  input  scanline_pkg::str_t                   sl_strength_i,
  input  logic [scanline_pkg::bloom_width-1:0] sl_bloom_i,
  output logic                                 HSYNC_o,
  output logic                                 VSYNC_o,
  output logic                                 DE_o,
  output scanline_pkg::vdata_t                 vdata_o
);

  scanline_pkg::color_t red_w, green_w, blue_w;

  // decode to execute, stage 2
  scanline_pkg::str_t dist_r_w, dist_g_w, dist_b_w;
  logic               draw2_r_w, draw2_g_w, draw2_b_w;
  logic               max_r_w, max_g_w, max_b_w;
  scanline_pkg::ref_t ref_r_w, ref_g_w, ref_b_w;

  // execute to result, stage 7
  scanline_pkg::str_t scale_r_w, scale_g_w, scale_b_w;
  logic               draw7_r_w, draw7_g_w, draw7_b_w;

  assign red_w   = vdata_i.r;
  assign green_w = vdata_i.g;
  assign blue_w  = vdata_i.b;

  scanline_decode decode0 (
    .VCLK_i          (VCLK_i),
    .nVRST_i         (nVRST_i),
    .r_i             (red_w),
    .g_i             (green_w),
    .b_i             (blue_w),
    .sl_per_channel_i(sl_per_channel_i),
    .sl_thickness_i  (sl_thickness_i),
    .sl_profile_i    (sl_profile_i),
    .sl_rel_pos_i    (sl_rel_pos_i),
    .dist_r_o        (dist_r_w),
    .dist_g_o        (dist_g_w),
    .dist_b_o        (dist_b_w),
    .draw_r_o        (draw2_r_w),
    .draw_g_o        (draw2_g_w),
    .draw_b_o        (draw2_b_w),
    .max_r_o         (max_r_w),
    .max_g_o         (max_g_w),
    .max_b_o         (max_b_w),
    .ref_r_o         (ref_r_w),
    .ref_g_o         (ref_g_w),
    .ref_b_o         (ref_b_w)
  );

  scanline_execute execute0 (
    .VCLK_i       (VCLK_i),
    .nVRST_i      (nVRST_i),
    .sl_en_i      (sl_en_i),
    .sl_profile_i (sl_profile_i),
    .sl_strength_i(sl_strength_i),
    .sl_bloom_i   (sl_bloom_i),
    .dist_r_i     (dist_r_w),
    .dist_g_i     (dist_g_w),
    .dist_b_i     (dist_b_w),
    .draw_r_i     (draw2_r_w),
    .draw_g_i     (draw2_g_w),
    .draw_b_i     (draw2_b_w),
    .max_r_i      (max_r_w),
    .max_g_i      (max_g_w),
    .max_b_i      (max_b_w),
    .ref_r_i      (ref_r_w),
    .ref_g_i      (ref_g_w),
    .ref_b_i      (ref_b_w),
    .scale_r_o    (scale_r_w),
    .scale_g_o    (scale_g_w),
    .scale_b_o    (scale_b_w),
    .draw_r_o     (draw7_r_w),
    .draw_g_o     (draw7_g_w),
    .draw_b_o     (draw7_b_w)
  );

  scanline_result result0 (
    .VCLK_i   (VCLK_i),
    .nVRST_i  (nVRST_i),
    .r_i      (red_w),
    .g_i      (green_w),
    .b_i      (blue_w),
    .hsync_i  (HSYNC_i),
    .vsync_i  (VSYNC_i),
    .de_i     (DE_i),
    .scale_r_i(scale_r_w),
    .scale_g_i(scale_g_w),
    .scale_b_i(scale_b_w),
    .draw_r_i (draw7_r_w),
    .draw_g_i (draw7_g_w),
    .draw_b_i (draw7_b_w),
    .hsync_o  (HSYNC_o),
    .vsync_o  (VSYNC_o),
    .de_o     (DE_o),
    .vdata_o  (vdata_o)
  );

endmodule

/* dv/scanline_checker.sv */
`timescale 1ns/1ps

module scanline_checker (
  input logic                 VCLK_i,
  input logic                 nVRST_i,
  input logic                 hsync_in_i,
  input logic                 vsync_in_i,
  input logic                 de_in_i,
  input logic                 hsync_out_i,
  input logic                 vsync_out_i,
  input logic                 de_out_i,
  input scanline_pkg::vdata_t vdata_out_i
);

  logic [3:0] warm_cnt;  // cycles since reset, stops at the depth
  int unsigned fail_cnt = 0;  // failed assertions so far

  always_ff @(posedge VCLK_i or negedge nVRST_i) begin
    if (!nVRST_i)
      warm_cnt <= '0;
    else if (warm_cnt != scanline_pkg::proc_stages)
      warm_cnt <= warm_cnt + 1'b1;
  end

  ////////////////////////////////////////
  // reset state and sync delay
  ////////////////////////////////////////

  // from the second clock in reset on
  reset_state_a : assert property (@(posedge VCLK_i)
    (!nVRST_i && $past(!nVRST_i)) |->
      (!hsync_out_i && !vsync_out_i && !de_out_i && vdata_out_i == '0))
    else begin
      $error("outputs are not cleared while reset is held");
      fail_cnt++;
    end

  hsync_delay_a : assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    (warm_cnt == scanline_pkg::proc_stages) |->
      (hsync_out_i == $past(hsync_in_i, scanline_pkg::proc_stages)))
    else begin
      $error("HSYNC_o does not follow HSYNC_i by the pipeline depth");
      fail_cnt++;
    end

  vsync_delay_a : assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    (warm_cnt == scanline_pkg::proc_stages) |->
      (vsync_out_i == $past(vsync_in_i, scanline_pkg::proc_stages)))
    else begin
      $error("VSYNC_o does not follow VSYNC_i by the pipeline depth");
      fail_cnt++;
    end

  de_delay_a : assert property (@(posedge VCLK_i) disable iff (!nVRST_i)
    (warm_cnt == scanline_pkg::proc_stages) |->
      (de_out_i == $past(de_in_i, scanline_pkg::proc_stages)))
    else begin
      $error("DE_o does not follow DE_i by the pipeline depth");
      fail_cnt++;
    end

endmodule

bind scanline_emu scanline_checker chk0 (
  .VCLK_i     (VCLK_i),
  .nVRST_i    (nVRST_i),
  .hsync_in_i (HSYNC_i),
  .vsync_in_i (VSYNC_i),
  .de_in_i    (DE_i),
  .hsync_out_i(HSYNC_o),
  .vsync_out_i(VSYNC_o),
  .de_out_i   (DE_o),
  .vdata_out_i(vdata_o)
);

/* dv/scanline_tb.sv */
`timescale 1ns/1ps

module scanline_tb;

  localparam int latency    = scanline_pkg::proc_stages;
  localparam int max_lines  = 1000;                          // trace length bound
  localparam int drain_wait = 4 * scanline_pkg::proc_stages;

  logic                                 vclk;
  logic                                 nvrst;
  logic                                 hsync, vsync, de;
  scanline_pkg::vdata_t                 vdata;
  logic                                 sl_en;
  logic                                 sl_per_channel;
  scanline_pkg::sl_thickness_e          sl_thickness;
  scanline_pkg::sl_profile_e            sl_profile;
  scanline_pkg::str_t                   sl_rel_pos;
  scanline_pkg::str_t                   sl_strength;
  logic [scanline_pkg::bloom_width-1:0] sl_bloom;

  logic                                 hsync_out, vsync_out, de_out;
  scanline_pkg::vdata_t                 vdata_out;

  // expected outputs, one entry per driven cycle
  string       name_q [$];
  logic [2:0]  sync_q [$];
  logic [23:0] pix_q [$];

  int checks   = 0;
  int errors   = 0;
  int timeouts = 0;

  scanline_emu dut0 (
    .VCLK_i          (vclk),
    .nVRST_i         (nvrst),
    .HSYNC_i         (hsync),
    .VSYNC_i         (vsync),
    .DE_i            (de),
    .vdata_i         (vdata),
    .sl_en_i         (sl_en),
    .sl_per_channel_i(sl_per_channel),
    .sl_thickness_i  (sl_thickness),
    .sl_profile_i    (sl_profile),
    .sl_rel_pos_i    (sl_rel_pos),
    .sl_strength_i   (sl_strength),
    .sl_bloom_i      (sl_bloom),
    .HSYNC_o         (hsync_out),
    .VSYNC_o         (vsync_out),
    .DE_o            (de_out),
    .vdata_o         (vdata_out)
  );

  initial begin
    vclk = 1'b0;
    forever #5 vclk = ~vclk;
  end

  ////////////////////////////////////////
  // checking
  ////////////////////////////////////////

  task automatic check_value(input string test, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[ERROR] %s: expected %0h, actual %0h", test, expected, actual);
    end
  endtask

  // oldest expected entry belongs to the current outputs
  task automatic check_output();
    string       test;
    logic [2:0]  sync_exp;
    logic [23:0] pix_exp;
    test     = name_q.pop_front();
    sync_exp = sync_q.pop_front();
    pix_exp  = pix_q.pop_front();
    check_value({test, " sync"}, sync_exp, {hsync_out, vsync_out, de_out});
    check_value({test, " vdata"}, pix_exp, vdata_out);
  endtask

  ////////////////////////////////////////
  // driving, called at the falling edge
  ////////////////////////////////////////

  task automatic step_pixel(input string test, input logic hs_v, input logic vs_v,
                            input logic de_v, input logic [23:0] pix_v,
                            input logic [23:0] exp_v);
    if (pix_q.size() == latency)
      check_output();
    hsync = hs_v;
    vsync = vs_v;
    de    = de_v;
    vdata = pix_v;
    name_q.push_back(test);
    sync_q.push_back({hs_v, vs_v, de_v});
    pix_q.push_back(exp_v);
  endtask

  // random syncs with DE low, so the pixel passes unchanged
  task automatic step_filler();
    logic [31:0] rnd;
    rnd = $urandom;
    step_pixel("filler", rnd[0], rnd[1], 1'b0, rnd[31:8], rnd[31:8]);
  endtask

  task automatic run_entry(input string test, input logic en_v, input logic pc_v,
                           input logic [1:0] thk_v, input logic prof_v,
                           input logic [7:0] pos_v, input logic [7:0] strength_v,
                           input logic [4:0] bloom_v, input logic hs_v, input logic vs_v,
                           input logic de_v, input logic [23:0] pix_v,
                           input logic [23:0] exp_v);
    @(negedge vclk);
    sl_en          = en_v;
    sl_per_channel = pc_v;
    sl_thickness   = scanline_pkg::sl_thickness_e'(thk_v);
    sl_profile     = scanline_pkg::sl_profile_e'(prof_v);
    sl_rel_pos     = pos_v;
    sl_strength    = strength_v;
    sl_bloom       = bloom_v;
    step_filler();
    repeat (latency - 1) begin
      @(negedge vclk);
      step_filler();
    end
    @(negedge vclk);
    step_pixel(test, hs_v, vs_v, de_v, pix_v, exp_v);
    // config held until the pixel has left the pipeline
    repeat (latency) begin
      @(negedge vclk);
      step_filler();
    end
  endtask

  ////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////

  initial begin
    int          fd;
    int          got;
    int          fields;
    int          lines_read;
    int          entries;
    int          waited;
    int          assert_fails;
    int unsigned seed_rnd;
    string       line;
    string       test;
    logic [31:0] en_v, pc_v, thk_v, prof_v, pos_v, strength_v, bloom_v;
    logic [31:0] hs_v, vs_v, de_v, pix_v, exp_v;

    seed_rnd       = $urandom(32'h0c4d9d56);
    nvrst          = 1'b0;
    hsync          = 1'b0;
    vsync          = 1'b0;
    de             = 1'b0;
    vdata          = '0;
    sl_en          = 1'b0;
    sl_per_channel = 1'b0;
    sl_thickness   = scanline_pkg::NORMAL;
    sl_profile     = scanline_pkg::RECT;
    sl_rel_pos     = '0;
    sl_strength    = '0;
    sl_bloom       = '0;
    lines_read     = 0;
    entries        = 0;

    repeat (scanline_pkg::proc_stages) @(negedge vclk);
    check_value("reset sync", 3'b000, {hsync_out, vsync_out, de_out});
    check_value("reset vdata", 24'h000000, vdata_out);
    nvrst = 1'b1;

    fd = $fopen("dv/scanline_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open the trace file dv/scanline_trace.txt");
    end else begin
      while (!$feof(fd) && lines_read < max_lines) begin
        lines_read++;
        line = "";
        got  = $fgets(line, fd);
        if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin  // skip comments
          fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h", test, en_v,
                           pc_v, thk_v, prof_v, pos_v, strength_v, bloom_v, hs_v, vs_v,
                           de_v, pix_v, exp_v);
          if (fields != 13) begin
            errors++;
            $display("trace line %0d could not be read", lines_read);
          end else begin
            entries++;
            run_entry(test, en_v[0], pc_v[0], thk_v[1:0], prof_v[0], pos_v[7:0],
                      strength_v[7:0], bloom_v[4:0], hs_v[0], vs_v[0], de_v[0],
                      pix_v[23:0], exp_v[23:0]);
          end
        end
      end
      $fclose(fd);
    end

    if (entries == 0) begin
      errors++;
      $display("no trace entries were run");
    end

    // pending outputs leave the pipeline one per cycle
    waited = 0;
    while (pix_q.size() > 0 && waited < drain_wait) begin
      @(negedge vclk);
      check_output();
      waited++;
    end
    if (pix_q.size() > 0) begin
      timeouts++;
      $display("timeout: %0d expected outputs were never compared", pix_q.size());
    end

    assert_fails = dut0.chk0.fail_cnt;

    $display("scanline_tb: %0d entries, %0d checks, %0d errors, %0d timeouts, %0d assertions",
             entries, checks, errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

/* dv/scanline_trace.txt */
# name en per_channel thickness profile rel_pos strength bloom hs vs de vdata expected (hex)
# thickness 0 thin 1 normal 2 thick 3 adaptive, profile 0 rect 1 flat top
pass_en_off      0 0 1 0 80 ff 00 0 0 1 8040c0 8040c0
pass_de_low      1 0 1 0 80 ff 00 1 0 0 123456 123456
sync_hv          1 0 1 0 80 ff 00 1 1 0 deadbe deadbe
thin_below       1 0 0 0 20 80 00 0 0 1 102030 102030
thin_slope       1 0 0 0 50 80 00 0 0 1 c08040 8e5f2f
thin_full        1 0 0 0 78 80 00 0 0 1 c08040 5f3f1f
normal_below     1 0 1 0 20 ff 00 0 0 1 405060 405060
normal_slope     1 0 1 0 38 ff 00 0 0 1 808080 4f4f4f
normal_full      1 0 1 0 80 ff 00 0 1 1 ffffff 000000
thick_below      1 0 2 0 08 c0 00 0 0 1 a0b0c0 a0b0c0
thick_slope      1 0 2 0 30 c0 00 0 0 1 646464 3d3d3d
thick_full       1 0 2 0 50 c0 00 0 0 1 c8c8c8 313131
thick_edge       1 0 2 0 11 ff 00 0 0 1 ff8000 fb7e00
adapt_luma       1 0 3 0 40 ff 00 0 0 1 4080c0 1f3f5e
adapt_luma_full  1 0 3 0 60 80 00 0 0 1 102030 070f17
adapt_round      1 0 3 0 02 ff 00 0 0 1 000400 000300
adapt_pc         1 1 3 0 30 ff 00 0 0 1 ff4008 ff1f02
adapt_pc_mix     1 1 3 0 60 80 00 0 0 1 80c020 3f760f
flat_low         1 0 1 1 38 80 00 0 0 1 808080 808080
flat_high        1 0 1 1 40 80 00 0 0 1 808080 3f3f3f
flat_below       1 0 1 1 10 80 00 0 0 1 405060 405060
bloom_full       1 1 1 0 80 80 1f 0 0 1 804020 7d2f13
bloom_clamp      1 1 1 0 80 40 1f 0 0 1 ff4010 fe370c
bloom_luma       1 0 0 0 60 ff 10 0 0 1 806040 423121
fold_50          1 0 1 0 50 80 00 0 0 1 808080 4f4f4f
fold_b0          1 0 1 0 b0 80 00 0 0 1 808080 4f4f4f
fold_70          1 0 0 0 70 80 00 1 0 1 c08040 5f3f1f
fold_90          1 0 0 0 90 80 00 1 0 1 c08040 5f3f1f

/* files.f */
design/scanline_pkg.sv
design/scanline_decode.sv
design/scanline_execute.sv
design/scanline_result.sv
design/scanline_emu.sv
dv/scanline_checker.sv
dv/scanline_tb.sv

/* Bender.yml */
package:
  name: scanline_emu

sources:
  # design, package first
  - design/scanline_pkg.sv
  - design/scanline_decode.sv
  - design/scanline_execute.sv
  - design/scanline_result.sv
  - design/scanline_emu.sv

  # verification
  - target: simulation
    files:
      - dv/scanline_checker.sv
      - dv/scanline_tb.sv
